//--- design/rv32_pipe_cfg.svh
`ifndef RV32_PIPE_CFG_SVH
`define RV32_PIPE_CFG_SVH

// Integer data path width
`define RV_XLEN 32

// Instruction memory word address, 64 words
`define RV_IMEM_AW 6

// Writeback credits granted by the consumer at reset
`define RV_WB_CREDITS 4

// ECALL encoding, SYSTEM opcode with all other fields zero
`define RV_ECALL 32'h0000_0073

`endif

//--- design/rv32_pipe_pkg.sv
`default_nettype none

`include "rv32_pipe_cfg.svh"

package rv32_pipe_pkg;

  // ALU operation select, PASSB forwards operand b for LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB
  } alu_op_e;

  // Host write into the instruction memory
  typedef struct packed {
    logic                   valid;
    logic [`RV_IMEM_AW-1:0] addr;
    logic [`RV_XLEN-1:0]    data;
  } imem_load_t;

  // Fetch read request
  typedef struct packed {
    logic                   valid;
    logic [`RV_IMEM_AW-1:0] addr;
  } fetch_req_t;

  // Decode to execute bundle
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    alu_op_e             alu_op;
    logic [`RV_XLEN-1:0] opa;
    logic [`RV_XLEN-1:0] opb;
    logic [4:0]          rd;
  } ex_payload_t;

  // Execute to retire bundle, also the writeback record
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] value;
  } wb_rec_t;

endpackage

`default_nettype wire

//--- design/rv32_stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_stage_reg #(
  parameter type payload_t = logic
) (
  input  wire           clk_i,
  input  wire           rst_n_i,
  input  wire           valid_i,
  input  wire payload_t data_i,
  input  wire           stall_i,
  output logic          valid_o,
  output payload_t      data_o,
  output logic          stall_o
);

  // Full and blocked downstream
  assign stall_o = valid_o & stall_i;

  // Unstalled, follow upstream valid which also drops a taken item
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else if (!stall_o) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && !stall_o) begin
      data_o <= data_i;
    end
  end

  // A blocked upstream item is offered again unchanged
  a_upstream_holds : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_o && valid_i |=> valid_i && $stable(data_i));

endmodule

`default_nettype wire

//--- design/rv32_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32_pipe_cfg.svh"

module rv32_regfile (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire [4:0]           rs1_addr_i,
  input  wire [4:0]           rs2_addr_i,
  output logic [`RV_XLEN-1:0] rs1_data_o,
  output logic [`RV_XLEN-1:0] rs2_data_o,
  input  wire                 we_i,
  input  wire [4:0]           rd_i,
  input  wire [`RV_XLEN-1:0]  wd_i
);

  logic [`RV_XLEN-1:0] regs_q [32];

  // x0 is cleared at reset and never written
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && rd_i != 5'd0) begin
      regs_q[rd_i] <= wd_i;
    end
  end

  // Asynchronous read ports
  assign rs1_data_o = regs_q[rs1_addr_i];
  assign rs2_data_o = regs_q[rs2_addr_i];

endmodule

`default_nettype wire

//--- design/rv32_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32_pipe_cfg.svh"

module rv32_alu import rv32_pipe_pkg::*; (
  input  wire alu_op_e        op_i,
  input  wire [`RV_XLEN-1:0]  a_i,
  input  wire [`RV_XLEN-1:0]  b_i,
  output logic [`RV_XLEN-1:0] y_o
);

  // Shift amount from the low bits only
  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:   y_o = a_i + b_i;
      ALU_SUB:   y_o = a_i - b_i;
      ALU_SLL:   y_o = a_i << shamt;
      // Set-less-than gives 0 or 1
      ALU_SLT:   y_o = {31'd0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU:  y_o = {31'd0, a_i < b_i};
      ALU_XOR:   y_o = a_i ^ b_i;
      ALU_SRL:   y_o = a_i >> shamt;
      ALU_SRA:   y_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:    y_o = a_i | b_i;
      ALU_AND:   y_o = a_i & b_i;
      // LUI result, immediate already shifted in decode
      ALU_PASSB: y_o = b_i;
      default:   y_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/rv32_imem_shared.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32_pipe_cfg.svh"

module rv32_imem_shared import rv32_pipe_pkg::*; (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire imem_load_t     load_i,
  input  wire fetch_req_t     fetch_req_i,
  output logic                grant_o,
  output logic                rdata_valid_o,
  output logic [`RV_XLEN-1:0] rdata_o
);

  // Single port storage
  logic [`RV_XLEN-1:0] mem_q [2**`RV_IMEM_AW];

  ////////////////////
  // Arbitration
  ////////////////////

  // Loader has fixed priority, a read only goes through on an idle port
  assign grant_o = fetch_req_i.valid & ~load_i.valid;

  // Write or read, one access per cycle
  always_ff @(posedge clk_i) begin
    if (load_i.valid) begin
      mem_q[load_i.addr] <= load_i.data;
    end else if (grant_o) begin
      rdata_o <= mem_q[fetch_req_i.addr];
    end
  end

  // Reply strobe one cycle behind the grant
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_valid_o <= 1'b0;
    end else begin
      rdata_valid_o <= grant_o;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // A loader cycle never returns read data on the next cycle
  a_load_blocks_read : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    load_i.valid |=> !rdata_valid_o);

endmodule

`default_nettype wire

//--- design/rv32_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32_pipe_cfg.svh"

module rv32_fetch import rv32_pipe_pkg::*; (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire                 run_i,
  output fetch_req_t          req_o,
  input  wire                 grant_i,
  input  wire                 rdata_valid_i,
  input  wire [`RV_XLEN-1:0]  rdata_i,
  input  wire                 hold_i,
  output logic                instr_valid_o,
  output logic [`RV_XLEN-1:0] instr_o,
  output logic [`RV_XLEN-1:0] pc_o,
  output logic                halted_o
);

  logic [`RV_XLEN-1:0] pc_q;
  // Pc of the read whose reply arrives this cycle
  logic [`RV_XLEN-1:0] rd_pc_q;
  logic                skid_valid_q;
  logic [`RV_XLEN-1:0] skid_instr_q;
  logic [`RV_XLEN-1:0] skid_pc_q;
  logic                reply_ecall;
  logic                reply_live;

  // ECALL is swallowed here and never reaches decode
  assign reply_ecall = rdata_valid_i && (rdata_i == `RV_ECALL);
  assign reply_live  = rdata_valid_i && !reply_ecall;

  // No new read while decode holds or once ECALL is seen
  assign req_o.valid = run_i && !halted_o && !reply_ecall && !hold_i;
  assign req_o.addr  = pc_q[`RV_IMEM_AW+1:2];

  // Skid entry takes precedence, a reply never coincides with it
  assign instr_valid_o = skid_valid_q | reply_live;
  assign instr_o       = skid_valid_q ? skid_instr_q : rdata_i;
  assign pc_o          = skid_valid_q ? skid_pc_q : rd_pc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q         <= '0;
      rd_pc_q      <= '0;
      skid_valid_q <= 1'b0;
      halted_o     <= 1'b0;
    end else begin
      // Advance only on a granted read
      if (grant_i) begin
        pc_q    <= pc_q + `RV_XLEN'(4);
        rd_pc_q <= pc_q;
      end
      // Park a reply that decode could not take
      if (reply_live && hold_i) begin
        skid_valid_q <= 1'b1;
      end else if (skid_valid_q && !hold_i) begin
        skid_valid_q <= 1'b0;
      end
      if (reply_ecall) begin
        halted_o <= 1'b1;
      end
    end
  end

  // Skid payload
  always_ff @(posedge clk_i) begin
    if (reply_live && hold_i) begin
      skid_instr_q <= rdata_i;
      skid_pc_q    <= rd_pc_q;
    end
  end

  // Memory replies only to granted reads, so none lands on a parked entry
  a_skid_no_reply : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    skid_valid_q |-> !rdata_valid_i);

endmodule

`default_nettype wire

//--- design/rv32_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32_pipe_cfg.svh"

module rv32_decode import rv32_pipe_pkg::*; (
  input  wire                instr_valid_i,
  input  wire [`RV_XLEN-1:0] instr_i,
  input  wire [`RV_XLEN-1:0] pc_i,
  output logic [4:0]         rs1_addr_o,
  output logic [4:0]         rs2_addr_o,
  input  wire [`RV_XLEN-1:0] rs1_data_i,
  input  wire [`RV_XLEN-1:0] rs2_data_i,
  input  wire [4:0]          ex_rd_i,
  input  wire [4:0]          wb_rd_i,
  input  wire                ex_stall_i,
  output logic               hold_o,
  output logic               ex_valid_o,
  output ex_payload_t        ex_o
);

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic                alt;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_sh;
  logic [`RV_XLEN-1:0] imm_u;
  logic                use_rs1;
  logic                use_rs2;
  logic                hazard;
  alu_op_e             op_f3;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  // funct7 bit 5 selects SUB and SRA
  assign alt    = instr_i[30];

  ////////////////////
  // Immediates
  ////////////////////

  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_sh = {27'd0, instr_i[24:20]};
  assign imm_u  = {instr_i[31:12], 12'd0};

  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  // Operation from funct3, alt only counts for SUB on reg-reg
  always_comb begin
    case (funct3)
      3'b000:  op_f3 = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  op_f3 = ALU_SLL;
      3'b010:  op_f3 = ALU_SLT;
      3'b011:  op_f3 = ALU_SLTU;
      3'b100:  op_f3 = ALU_XOR;
      3'b101:  op_f3 = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op_f3 = ALU_OR;
      default: op_f3 = ALU_AND;
    endcase
  end

  always_comb begin
    ex_o.pc     = pc_i;
    ex_o.alu_op = ALU_ADD;
    ex_o.opa    = '0;
    ex_o.opb    = '0;
    // Unknown opcodes retire as no-op with rd of zero
    ex_o.rd     = '0;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        ex_o.alu_op = op_f3;
        ex_o.opa    = rs1_data_i;
        ex_o.opb    = (funct3 == 3'b001 || funct3 == 3'b101) ? imm_sh : imm_i;
        ex_o.rd     = instr_i[11:7];
        use_rs1     = 1'b1;
      end
      OPC_OP: begin
        ex_o.alu_op = op_f3;
        ex_o.opa    = rs1_data_i;
        ex_o.opb    = rs2_data_i;
        ex_o.rd     = instr_i[11:7];
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
      end
      OPC_LUI: begin
        ex_o.alu_op = ALU_PASSB;
        ex_o.opb    = imm_u;
        ex_o.rd     = instr_i[11:7];
      end
      default: begin
        ex_o.rd = '0;
      end
    endcase
  end

  ////////////////////
  // Hazard hold
  ////////////////////

  // x0 sources never wait, so a zero rd never matches
  assign hazard = (use_rs1 && rs1_addr_o != 5'd0 &&
                   (rs1_addr_o == ex_rd_i || rs1_addr_o == wb_rd_i)) ||
                  (use_rs2 && rs2_addr_o != 5'd0 &&
                   (rs2_addr_o == ex_rd_i || rs2_addr_o == wb_rd_i));

  assign ex_valid_o = instr_valid_i & ~hazard;
  assign hold_o     = instr_valid_i & (hazard | ex_stall_i);

endmodule

`default_nettype wire

//--- design/rv32_retire.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32_pipe_cfg.svh"

module rv32_retire import rv32_pipe_pkg::*; (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire                 valid_i,
  input  wire wb_rec_t        rec_i,
  output logic                stall_o,
  input  wire                 wb_credit_i,
  output logic                wb_valid_o,
  output wb_rec_t             wb_o,
  output logic                rf_we_o,
  output logic [4:0]          rf_rd_o,
  output logic [`RV_XLEN-1:0] rf_wd_o
);

  localparam int CW = $clog2(`RV_WB_CREDITS + 1);

  logic [CW-1:0] credit_q;

  ////////////////////
  // Credit handshake
  ////////////////////

  // No credit left, back-pressure the wb stage
  assign stall_o    = (credit_q == '0);
  assign wb_valid_o = valid_i & ~stall_o;
  assign wb_o       = rec_i;

  // One credit per emission, one back per returned pulse
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= CW'(`RV_WB_CREDITS);
    end else begin
      credit_q <= credit_q - CW'(wb_valid_o) + CW'(wb_credit_i);
    end
  end

  // Register file commits with the emission
  assign rf_we_o = wb_valid_o & (rec_i.rd != 5'd0);
  assign rf_rd_o = rec_i.rd;
  assign rf_wd_o = rec_i.value;

  // Consumer never returns more than it was granted
  a_credit_max : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_q <= CW'(`RV_WB_CREDITS));

  // Out of credit with nothing returned, next cycle stays silent
  a_no_emit_at_zero : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (credit_q == '0 && !wb_credit_i) |=> !wb_valid_o);

endmodule

`default_nettype wire

//--- design/rv32_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32_pipe_cfg.svh"

module rv32_pipe_top import rv32_pipe_pkg::*; (
  input  wire             clk_i,
  input  wire             rst_n_i,
  input  wire imem_load_t load_i,
  input  wire             run_i,
  input  wire             wb_credit_i,
  output logic            wb_valid_o,
  output wb_rec_t         wb_o,
  output logic            halted_o
);

  ////////////////////
  // Fetch side
  ////////////////////

  fetch_req_t          fetch_req;
  logic                imem_grant;
  logic                imem_rvalid;
  logic [`RV_XLEN-1:0] imem_rdata;
  logic                instr_valid;
  logic [`RV_XLEN-1:0] instr;
  logic [`RV_XLEN-1:0] instr_pc;
  logic                dec_hold;

  // Decode and operand read
  logic [4:0]          rs1_addr;
  logic [4:0]          rs2_addr;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic                dec_valid;
  ex_payload_t         dec_ex;
  logic [4:0]          ex_rd_fb;
  logic [4:0]          wb_rd_fb;

  // Execute and retire
  logic                ex_stall;
  logic                ex_valid;
  ex_payload_t         ex_q;
  logic [`RV_XLEN-1:0] alu_y;
  wb_rec_t             wb_in;
  logic                wb_stall;
  logic                wb_valid;
  wb_rec_t             wb_q;
  logic                ret_stall;
  logic                rf_we;
  logic [4:0]          rf_rd;
  logic [`RV_XLEN-1:0] rf_wd;

  rv32_imem_shared u_imem (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .load_i        (load_i),
    .fetch_req_i   (fetch_req),
    .grant_o       (imem_grant),
    .rdata_valid_o (imem_rvalid),
    .rdata_o       (imem_rdata)
  );

  rv32_fetch u_fetch (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .run_i         (run_i),
    .req_o         (fetch_req),
    .grant_i       (imem_grant),
    .rdata_valid_i (imem_rvalid),
    .rdata_i       (imem_rdata),
    .hold_i        (dec_hold),
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .pc_o          (instr_pc),
    .halted_o      (halted_o)
  );

  // Only an occupied stage counts as a pending writer
  assign ex_rd_fb = ex_valid ? ex_q.rd : 5'd0;
  assign wb_rd_fb = wb_valid ? wb_q.rd : 5'd0;

  rv32_decode u_decode (
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (instr_pc),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .ex_rd_i       (ex_rd_fb),
    .wb_rd_i       (wb_rd_fb),
    .ex_stall_i    (ex_stall),
    .hold_o        (dec_hold),
    .ex_valid_o    (dec_valid),
    .ex_o          (dec_ex)
  );

  rv32_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .rd_i       (rf_rd),
    .wd_i       (rf_wd)
  );

  ////////////////////
  // Execute
  ////////////////////

  rv32_stage_reg #(
    .payload_t (ex_payload_t)
  ) u_ex_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (dec_valid),
    .data_i  (dec_ex),
    .stall_i (wb_stall),
    .valid_o (ex_valid),
    .data_o  (ex_q),
    .stall_o (ex_stall)
  );

  rv32_alu u_alu (
    .op_i (ex_q.alu_op),
    .a_i  (ex_q.opa),
    .b_i  (ex_q.opb),
    .y_o  (alu_y)
  );

  assign wb_in = '{pc: ex_q.pc, rd: ex_q.rd, value: alu_y};

  rv32_stage_reg #(
    .payload_t (wb_rec_t)
  ) u_wb_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (ex_valid),
    .data_i  (wb_in),
    .stall_i (ret_stall),
    .valid_o (wb_valid),
    .data_o  (wb_q),
    .stall_o (wb_stall)
  );

  rv32_retire u_retire (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (wb_valid),
    .rec_i       (wb_q),
    .stall_o     (ret_stall),
    .wb_credit_i (wb_credit_i),
    .wb_valid_o  (wb_valid_o),
    .wb_o        (wb_o),
    .rf_we_o     (rf_we),
    .rf_rd_o     (rf_rd),
    .rf_wd_o     (rf_wd)
  );

endmodule

`default_nettype wire

//--- verif/rv32_pipe_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32_pipe_cfg.svh"

module rv32_pipe_tb import rv32_pipe_pkg::*; ();

  logic       clk_i;
  logic       rst_n_i;
  imem_load_t load_i;
  logic       run_i;
  logic       wb_credit_i;
  logic       wb_valid_o;
  wb_rec_t    wb_o;
  logic       halted_o;

  // Program table, entry k sits at pc 4k
  string       name_q[$];
  logic [31:0] instr_q[$];
  logic [4:0]  rd_q[$];
  logic [31:0] val_q[$];

  int n_entries;
  int cycle_limit;
  int cycle_cnt   = 0;
  int rec_idx     = 0;
  int outstanding = 0;
  int run_negs    = 0;

  rv32_pipe_top dut_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .load_i      (load_i),
    .run_i       (run_i),
    .wb_credit_i (wb_credit_i),
    .wb_valid_o  (wb_valid_o),
    .wb_o        (wb_o),
    .halted_o    (halted_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_rec(input string name, input wb_rec_t exp, input wb_rec_t act);
    if (act !== exp) begin
      stop_with_error($sformatf(
        "mismatch %s expected pc=%h rd=%0d value=%h actual pc=%h rd=%0d value=%h",
        name, exp.pc, exp.rd, exp.value, act.pc, act.rd, act.value));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    end
  endtask

  // 32-bit xorshift step
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // RV32I encoders for the three formats in use
  function automatic logic [31:0] encode_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] encode_reg(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic add_entry(input string name, input logic [31:0] instr,
                           input logic [4:0] rd, input logic [31:0] value);
    name_q.push_back(name);
    instr_q.push_back(instr);
    rd_q.push_back(rd);
    val_q.push_back(value);
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic build_table();
    // Immediate forms, then LUI chains
    add_entry("addi", encode_imm(12'h005, 5'd0, 3'b000, 5'd1), 5'd1, 32'h0000_0005);
    add_entry("addi neg", encode_imm(12'hFFD, 5'd0, 3'b000, 5'd2), 5'd2, 32'hFFFF_FFFD);
    add_entry("lui", encode_lui(20'h12345, 5'd3), 5'd3, 32'h1234_5000);
    add_entry("ori", encode_imm(12'h678, 5'd3, 3'b110, 5'd4), 5'd4, 32'h1234_5678);
    add_entry("xori", encode_imm(12'hFFF, 5'd4, 3'b100, 5'd5), 5'd5, 32'hEDCB_A987);
    add_entry("andi", encode_imm(12'h0F0, 5'd4, 3'b111, 5'd6), 5'd6, 32'h0000_0070);
    add_entry("slti", encode_imm(12'h000, 5'd2, 3'b010, 5'd7), 5'd7, 32'h0000_0001);
    add_entry("sltiu", encode_imm(12'h001, 5'd2, 3'b011, 5'd8), 5'd8, 32'h0000_0000);
    add_entry("slli", encode_imm(12'h004, 5'd1, 3'b001, 5'd9), 5'd9, 32'h0000_0050);
    add_entry("srli", encode_imm(12'h01C, 5'd2, 3'b101, 5'd10), 5'd10, 32'h0000_000F);
    add_entry("srai", encode_imm(12'h401, 5'd2, 3'b101, 5'd11), 5'd11, 32'hFFFF_FFFE);
    // Reg-reg chain, mostly reading results still in flight
    add_entry("add", encode_reg(7'h00, 5'd2, 5'd1, 3'b000, 5'd12), 5'd12, 32'h0000_0002);
    add_entry("sub", encode_reg(7'h20, 5'd1, 5'd12, 3'b000, 5'd13), 5'd13, 32'hFFFF_FFFD);
    add_entry("sll", encode_reg(7'h00, 5'd13, 5'd1, 3'b001, 5'd14), 5'd14, 32'hA000_0000);
    add_entry("slt", encode_reg(7'h00, 5'd1, 5'd14, 3'b010, 5'd15), 5'd15, 32'h0000_0001);
    add_entry("sltu", encode_reg(7'h00, 5'd1, 5'd14, 3'b011, 5'd16), 5'd16, 32'h0000_0000);
    add_entry("xor", encode_reg(7'h00, 5'd4, 5'd14, 3'b100, 5'd17), 5'd17, 32'hB234_5678);
    add_entry("srl", encode_reg(7'h00, 5'd1, 5'd17, 3'b101, 5'd18), 5'd18, 32'h0591_A2B3);
    add_entry("sra", encode_reg(7'h20, 5'd1, 5'd17, 3'b101, 5'd19), 5'd19, 32'hFD91_A2B3);
    add_entry("or", encode_reg(7'h00, 5'd19, 5'd18, 3'b110, 5'd20), 5'd20, 32'hFD91_A2B3);
    add_entry("and", encode_reg(7'h00, 5'd6, 5'd20, 3'b111, 5'd21), 5'd21, 32'h0000_0030);
    // x0 target, then x0 as a source
    add_entry("addi x0", encode_imm(12'h007, 5'd1, 3'b000, 5'd0), 5'd0, 32'h0000_000C);
    add_entry("add from x0", encode_reg(7'h00, 5'd1, 5'd0, 3'b000, 5'd22), 5'd22, 32'h5);
    add_entry("sub from x0", encode_reg(7'h20, 5'd22, 5'd0, 3'b000, 5'd23), 5'd23,
              32'hFFFF_FFFB);
    // Custom-0 opcode with live rd and rs1 fields is a no-op
    add_entry("unknown op", 32'h1230_8F8B, 5'd0, 32'h0000_0000);
    add_entry("lui high", encode_lui(20'hFFFFF, 5'd24), 5'd24, 32'hFFFF_F000);
    add_entry("addi max", encode_imm(12'h7FF, 5'd24, 3'b000, 5'd25), 5'd25, 32'hFFFF_F7FF);
    add_entry("slt neg", encode_reg(7'h00, 5'd24, 5'd25, 3'b010, 5'd26), 5'd26, 32'h0);
    add_entry("sltu high", encode_reg(7'h00, 5'd25, 5'd24, 3'b011, 5'd27), 5'd27, 32'h1);
  endtask

  // One loader write per cycle
  task automatic write_imem(input logic [`RV_IMEM_AW-1:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    #1;
    load_i.valid = 1'b1;
    load_i.addr  = addr;
    load_i.data  = data;
  endtask

  task automatic release_loader();
    @(posedge clk_i);
    #1;
    load_i = '0;
  endtask

  ////////////////////
  // Consumer side
  ////////////////////

  // Returns one credit per pulse after a random gap
  initial begin : credit_driver
    logic [31:0] rng;
    int          gap_left;
    rng         = 32'd47487;
    gap_left    = 0;
    wb_credit_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (gap_left > 0) begin
        wb_credit_i = 1'b0;
        gap_left--;
      end else if (outstanding > 0) begin
        wb_credit_i = 1'b1;
        rng         = next_random(rng);
        gap_left    = int'(rng % 32'd8);
      end else begin
        wb_credit_i = 1'b0;
      end
    end
  end

  // Records emitted minus credits handed back
  always @(negedge clk_i) begin : credit_accounting
    if (rst_n_i) begin
      outstanding = outstanding + (wb_valid_o ? 1 : 0) - (wb_credit_i ? 1 : 0);
      if (outstanding > `RV_WB_CREDITS) begin
        stop_with_error($sformatf("record emitted with no credit left, %0d outstanding",
                                  outstanding));
      end
    end
  end

  // In-order compare of every retired record
  always @(negedge clk_i) begin : retire_monitor
    wb_rec_t exp_rec;
    if (run_i) begin
      run_negs++;
    end
    if (rst_n_i && wb_valid_o) begin
      if (run_negs < 4) begin
        stop_with_error("record emitted too early after run_i rose");
      end else if (rec_idx >= n_entries) begin
        stop_with_error("extra record after the last table entry");
      end else begin
        exp_rec.pc    = 32'(rec_idx * 4);
        exp_rec.rd    = rd_q[rec_idx];
        exp_rec.value = val_q[rec_idx];
        check_rec(name_q[rec_idx], exp_rec, wb_o);
        rec_idx++;
      end
    end
  end

  // Run limit from the table length
  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      stop_with_error($sformatf("timeout after %0d cycles, %0d of %0d records retired",
                                cycle_cnt, rec_idx, n_entries));
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main_seq
    int k;
    rst_n_i = 1'b0;
    run_i   = 1'b0;
    load_i  = '0;
    build_table();
    n_entries   = name_q.size();
    cycle_limit = 20 * n_entries + 200;

    repeat (16) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("wb_valid after reset", 1'b0, wb_valid_o);
    check_flag("halted after reset", 1'b0, halted_o);

    // Program image with ECALL right after the table
    for (k = 0; k < n_entries; k++) begin
      write_imem(`RV_IMEM_AW'(k), instr_q[k]);
    end
    write_imem(`RV_IMEM_AW'(n_entries), `RV_ECALL);
    release_loader();

    @(posedge clk_i);
    #1 run_i = 1'b1;

    // Loader steals the port from fetch for a few cycles
    repeat (2) @(posedge clk_i);
    for (k = 61; k < 64; k++) begin
      write_imem(`RV_IMEM_AW'(k), 32'hA5A5_0000 | 32'(k));
    end
    release_loader();

    while (rec_idx < n_entries) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    check_flag("halted at last retire", 1'b1, halted_o);

    // Quiet window, ECALL must not retire
    repeat (40) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("halted stays high", 1'b1, halted_o);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- rv32_pipe_top.f
+incdir+design
design/rv32_pipe_pkg.sv
design/rv32_stage_reg.sv
design/rv32_regfile.sv
design/rv32_alu.sv
design/rv32_imem_shared.sv
design/rv32_fetch.sv
design/rv32_decode.sv
design/rv32_retire.sv
design/rv32_pipe_top.sv
verif/rv32_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv32_pipe_top.f \
  --top-module rv32_pipe_tb -Mdir obj_dir -o rv32_pipe_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/rv32_pipe_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1
